// ==== src/axi_trace_pkg.sv ====
package axi_trace_pkg;

  // bus widths
  localparam int addr_w = 32;
  localparam int id_w = 8;
  localparam int len_w = 8;
  localparam int size_w = 3;
  localparam int resp_w = 2;

  // trace record fields
  localparam int ts_w = 14;
  localparam int chan_w = 2;
  localparam int rec_w = chan_w + ts_w + id_w + addr_w + len_w;

  localparam int num_chan = 3;

  typedef logic [chan_w-1:0] chan_t;
  typedef logic [ts_w-1:0] ts_t;

  // channel codes, vector index is code minus one
  localparam chan_t chan_none = 2'd0;
  localparam chan_t chan_ar = 2'd1;
  localparam chan_t chan_aw = 2'd2;
  localparam chan_t chan_b = 2'd3;

  // one AR or AW address beat
  typedef struct packed {
    logic [id_w-1:0] id;
    logic [addr_w-1:0] addr;
    logic [len_w-1:0] len;
    logic [size_w-1:0] size;
  } ax_beat_t;

  // one write response
  typedef struct packed {
    logic [id_w-1:0] id;
    logic [resp_w-1:0] resp;
  } b_beat_t;

  // one stream beat, chan in the top bits
  typedef struct packed {
    chan_t chan;
    ts_t ts;
    logic [id_w-1:0] id;
    logic [addr_w-1:0] addr;
    logic [len_w-1:0] len;
  } trace_rec_t;

  function automatic trace_rec_t ax_record(ax_beat_t beat, chan_t chan, ts_t ts);
    trace_rec_t rec;
    rec.chan = chan;
    rec.ts = ts;
    rec.id = beat.id;
    rec.addr = beat.addr;
    rec.len = beat.len;
    return rec;
  endfunction

  // resp goes in the low addr bits, len stays zero
  function automatic trace_rec_t b_record(b_beat_t beat, chan_t chan, ts_t ts);
    trace_rec_t rec;
    rec.chan = chan;
    rec.ts = ts;
    rec.id = beat.id;
    rec.addr = {{(addr_w - resp_w){1'b0}}, beat.resp};
    rec.len = '0;
    return rec;
  endfunction

endpackage

// ==== src/channel_tap.sv ====
`timescale 1ns/1ps

module channel_tap #(
  parameter type payload_t = logic,
  parameter axi_trace_pkg::chan_t chan_code = axi_trace_pkg::chan_none
) (
  input  logic                 clk,
  input  logic                 resetn,
  input  logic                 enable,

  // manager side
  input  payload_t             in_payload,
  input  logic                 in_valid,
  output logic                 in_ready,

  // subordinate side
  output payload_t             out_payload,
  output logic                 out_valid,
  input  logic                 out_ready,

  // scheduler side
  input  axi_trace_pkg::ts_t   ts,
  input  logic                 grant,
  output logic                 pending,
  output payload_t             captured,
  output axi_trace_pkg::ts_t   captured_ts
);

  logic handshake;
  logic capture;

  // channel is held off while a record waits for the scheduler
  assign out_payload = in_payload;
  assign out_valid = in_valid && !pending;
  assign in_ready = out_ready && !pending;

  assign handshake = in_valid && in_ready;
  assign capture = handshake && enable;

  // pending flag
  always_ff @(posedge clk) begin
    if (!resetn) begin
      pending <= 1'b0;
    end else if (capture) begin
      pending <= 1'b1;
    end else if (grant) begin
      pending <= 1'b0;
    end
  end

  // beat and stamp, only loaded on a traced handshake
  always_ff @(posedge clk) begin
    if (capture) begin
      captured <= in_payload;
      captured_ts <= ts;
    end
  end

  // a held record stays put until the scheduler takes it
  a_stall_while_pending: assert property (
    @(posedge clk) disable iff (!resetn)
    pending && !grant |=> pending && $stable(captured) && $stable(captured_ts)
  ) else $error("tap %0d: pending record lost or overwritten before grant", chan_code);

  // scheduler only grants a tap that asked
  a_grant_needs_pending: assert property (
    @(posedge clk) disable iff (!resetn)
    grant |-> pending
  ) else $error("tap %0d: grant without pending record", chan_code);

endmodule

// ==== src/trace_scheduler.sv ====
`timescale 1ns/1ps

module trace_scheduler (
  input  logic                                                   clk,
  input  logic                                                   resetn,

  output axi_trace_pkg::ts_t                                     ts,

  // one request and record per channel, index is code minus one
  input  logic [axi_trace_pkg::num_chan-1:0]                     req,
  input  axi_trace_pkg::trace_rec_t [axi_trace_pkg::num_chan-1:0] recs,
  output logic [axi_trace_pkg::num_chan-1:0]                     grant,

  // stream output
  output axi_trace_pkg::trace_rec_t                              rec_tdata,
  output logic                                                   rec_tvalid,
  input  logic                                                   rec_tready
);

  // requests as seen one cycle late
  logic [axi_trace_pkg::num_chan-1:0] req_q;
  logic [axi_trace_pkg::num_chan-1:0] eligible;

  // chan_w bits are enough to index num_chan channels
  logic [axi_trace_pkg::chan_w-1:0] last_idx;
  logic [axi_trace_pkg::chan_w-1:0] win_idx;
  logic win_found;

  logic can_load;
  logic load;

  // free-running timestamp, wraps
  always_ff @(posedge clk) begin
    if (!resetn) begin
      ts <= '0;
    end else begin
      ts <= ts + 1'b1;
    end
  end

  // registered request stage
  // the channel just granted drops out at once
  always_ff @(posedge clk) begin
    if (!resetn) begin
      req_q <= '0;
    end else begin
      req_q <= req & ~grant;
    end
  end

  assign eligible = req & req_q;

  // output register free now or emptied this cycle
  assign can_load = !rec_tvalid || rec_tready;

  // round robin, search starts just after the last winner
  always_comb begin
    logic [axi_trace_pkg::chan_w-1:0] cand;
    win_found = 1'b0;
    win_idx = last_idx;
    grant = '0;
    for (int i = 1; i <= axi_trace_pkg::num_chan; i++) begin
      cand = axi_trace_pkg::chan_w'((int'(last_idx) + i) % axi_trace_pkg::num_chan);
      if (!win_found && eligible[cand]) begin
        win_found = 1'b1;
        win_idx = cand;
      end
    end
    if (win_found && can_load) begin
      grant[win_idx] = 1'b1;
    end
  end

  assign load = |grant;

  // pointer starts on B so AR wins first
  always_ff @(posedge clk) begin
    if (!resetn) begin
      rec_tvalid <= 1'b0;
      last_idx <= axi_trace_pkg::chan_w'(axi_trace_pkg::num_chan - 1);
    end else if (load) begin
      rec_tvalid <= 1'b1;
      last_idx <= win_idx;
    end else if (rec_tready) begin
      rec_tvalid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      rec_tdata <= recs[win_idx];
    end
  end

  a_grant_onehot: assert property (
    @(posedge clk) disable iff (!resetn)
    $onehot0(grant)
  ) else $error("more than one grant in a cycle");

  // stalled beat keeps valid and data
  a_hold_under_backpressure: assert property (
    @(posedge clk) disable iff (!resetn)
    rec_tvalid && !rec_tready |=> rec_tvalid && $stable(rec_tdata)
  ) else $error("stream beat changed while stalled");

endmodule

// ==== src/axi_trace_top.sv ====
`timescale 1ns/1ps

module axi_trace_top (
  input  logic                                  clk,
  input  logic                                  resetn,
  input  logic [axi_trace_pkg::num_chan-1:0]    trace_enable,

  // AR channel
  input  axi_trace_pkg::ax_beat_t               ar_in,
  input  logic                                  ar_in_valid,
  output logic                                  ar_in_ready,
  output axi_trace_pkg::ax_beat_t               ar_out,
  output logic                                  ar_out_valid,
  input  logic                                  ar_out_ready,

  // AW channel
  input  axi_trace_pkg::ax_beat_t               aw_in,
  input  logic                                  aw_in_valid,
  output logic                                  aw_in_ready,
  output axi_trace_pkg::ax_beat_t               aw_out,
  output logic                                  aw_out_valid,
  input  logic                                  aw_out_ready,

  // B channel, in from the subordinate
  input  axi_trace_pkg::b_beat_t                b_in,
  input  logic                                  b_in_valid,
  output logic                                  b_in_ready,
  output axi_trace_pkg::b_beat_t                b_out,
  output logic                                  b_out_valid,
  input  logic                                  b_out_ready,

  // trace stream
  output axi_trace_pkg::trace_rec_t             rec_tdata,
  output logic                                  rec_tvalid,
  input  logic                                  rec_tready
);

  axi_trace_pkg::ts_t ts;
  logic [axi_trace_pkg::num_chan-1:0] req;
  logic [axi_trace_pkg::num_chan-1:0] grant;
  axi_trace_pkg::trace_rec_t [axi_trace_pkg::num_chan-1:0] recs;

  axi_trace_pkg::ax_beat_t ar_captured;
  axi_trace_pkg::ax_beat_t aw_captured;
  axi_trace_pkg::b_beat_t b_captured;
  axi_trace_pkg::ts_t ar_captured_ts;
  axi_trace_pkg::ts_t aw_captured_ts;
  axi_trace_pkg::ts_t b_captured_ts;

  channel_tap #(
    .payload_t (axi_trace_pkg::ax_beat_t),
    .chan_code (axi_trace_pkg::chan_ar)
  ) u_tap_ar (
    .clk         (clk),
    .resetn      (resetn),
    .enable      (trace_enable[axi_trace_pkg::chan_ar - 1]),
    .in_payload  (ar_in),
    .in_valid    (ar_in_valid),
    .in_ready    (ar_in_ready),
    .out_payload (ar_out),
    .out_valid   (ar_out_valid),
    .out_ready   (ar_out_ready),
    .ts          (ts),
    .grant       (grant[axi_trace_pkg::chan_ar - 1]),
    .pending     (req[axi_trace_pkg::chan_ar - 1]),
    .captured    (ar_captured),
    .captured_ts (ar_captured_ts)
  );

  channel_tap #(
    .payload_t (axi_trace_pkg::ax_beat_t),
    .chan_code (axi_trace_pkg::chan_aw)
  ) u_tap_aw (
    .clk         (clk),
    .resetn      (resetn),
    .enable      (trace_enable[axi_trace_pkg::chan_aw - 1]),
    .in_payload  (aw_in),
    .in_valid    (aw_in_valid),
    .in_ready    (aw_in_ready),
    .out_payload (aw_out),
    .out_valid   (aw_out_valid),
    .out_ready   (aw_out_ready),
    .ts          (ts),
    .grant       (grant[axi_trace_pkg::chan_aw - 1]),
    .pending     (req[axi_trace_pkg::chan_aw - 1]),
    .captured    (aw_captured),
    .captured_ts (aw_captured_ts)
  );

  channel_tap #(
    .payload_t (axi_trace_pkg::b_beat_t),
    .chan_code (axi_trace_pkg::chan_b)
  ) u_tap_b (
    .clk         (clk),
    .resetn      (resetn),
    .enable      (trace_enable[axi_trace_pkg::chan_b - 1]),
    .in_payload  (b_in),
    .in_valid    (b_in_valid),
    .in_ready    (b_in_ready),
    .out_payload (b_out),
    .out_valid   (b_out_valid),
    .out_ready   (b_out_ready),
    .ts          (ts),
    .grant       (grant[axi_trace_pkg::chan_b - 1]),
    .pending     (req[axi_trace_pkg::chan_b - 1]),
    .captured    (b_captured),
    .captured_ts (b_captured_ts)
  );

  // records built from the held beats
  assign recs[axi_trace_pkg::chan_ar - 1] =
    axi_trace_pkg::ax_record(ar_captured, axi_trace_pkg::chan_ar, ar_captured_ts);
  assign recs[axi_trace_pkg::chan_aw - 1] =
    axi_trace_pkg::ax_record(aw_captured, axi_trace_pkg::chan_aw, aw_captured_ts);
  assign recs[axi_trace_pkg::chan_b - 1] =
    axi_trace_pkg::b_record(b_captured, axi_trace_pkg::chan_b, b_captured_ts);

  trace_scheduler u_sched (
    .clk        (clk),
    .resetn     (resetn),
    .ts         (ts),
    .req        (req),
    .recs       (recs),
    .grant      (grant),
    .rec_tdata  (rec_tdata),
    .rec_tvalid (rec_tvalid),
    .rec_tready (rec_tready)
  );

endmodule

// ==== verification/axi_trace_tests.svh ====
task automatic report_error(input string msg);
  err_count++;
  $display("[ERROR] %0t: %s", $time, msg);
endtask

function automatic axi_trace_pkg::ax_beat_t random_ax();
  axi_trace_pkg::ax_beat_t beat;
  beat.id = axi_trace_pkg::id_w'($urandom);
  beat.addr = $urandom;
  beat.len = axi_trace_pkg::len_w'($urandom);
  beat.size = axi_trace_pkg::size_w'($urandom);
  return beat;
endfunction

// holds valid until the handshake edge, returns that edge number
task automatic wait_ax(input bit to_aw, input axi_trace_pkg::ax_beat_t beat,
                       output int hs_cyc);
  logic rdy;
  logic ovalid;
  axi_trace_pkg::ax_beat_t opay;
  rdy = 1'b0;
  while (!rdy) begin
    #1;
    rdy = to_aw ? aw_in_ready : ar_in_ready;
    ovalid = to_aw ? aw_out_valid : ar_out_valid;
    opay = to_aw ? aw_out : ar_out;
    if (rdy && (!ovalid || opay !== beat)) begin
      report_error("address beat not passed through unchanged");
    end
    @(negedge clk);
  end
  hs_cyc = cyc;
  if (to_aw) aw_in_valid = 1'b0;
  else ar_in_valid = 1'b0;
endtask

task automatic send_ax(input bit to_aw, input axi_trace_pkg::ax_beat_t beat,
                       output int hs_cyc);
  @(negedge clk);
  if (to_aw) begin
    aw_in = beat;
    aw_in_valid = 1'b1;
  end else begin
    ar_in = beat;
    ar_in_valid = 1'b1;
  end
  wait_ax(to_aw, beat, hs_cyc);
endtask

task automatic send_b(input axi_trace_pkg::b_beat_t beat);
  @(negedge clk);
  b_in = beat;
  b_in_valid = 1'b1;
  #1;
  while (!b_in_ready) begin
    @(negedge clk);
    #1;
  end
  if (!b_out_valid || b_out !== beat) begin
    report_error("B beat not passed through unchanged");
  end
  @(negedge clk);
  b_in_valid = 1'b0;
endtask

task automatic wait_records(input int n);
  while (rec_q.size() < n) @(negedge clk);
endtask

task automatic drain();
  repeat (8) @(negedge clk);
  rec_q.delete();
endtask

task automatic check_ax_rec(input axi_trace_pkg::trace_rec_t rec,
                            input axi_trace_pkg::chan_t chan,
                            input axi_trace_pkg::ax_beat_t beat);
  if (rec.chan !== chan || rec.id !== beat.id || rec.addr !== beat.addr ||
      rec.len !== beat.len) begin
    report_error($sformatf("record %h does not match beat %h on channel %0d",
                           rec, beat, chan));
  end
endtask

task automatic test_round_robin();
  axi_trace_pkg::ax_beat_t ar_beat;
  axi_trace_pkg::ax_beat_t aw_beat;
  for (int round = 0; round < 2; round++) begin
    ar_beat = random_ax();
    aw_beat = random_ax();
    @(negedge clk);
    ar_in = ar_beat;
    aw_in = aw_beat;
    b_in = '{id: 8'h5a, resp: 2'b10};
    ar_in_valid = 1'b1;
    aw_in_valid = 1'b1;
    b_in_valid = 1'b1;
    #1;
    if (!ar_in_ready || !aw_in_ready || !b_in_ready) begin
      report_error("channels not ready for a same-cycle handshake");
    end
    @(negedge clk);
    ar_in_valid = 1'b0;
    aw_in_valid = 1'b0;
    b_in_valid = 1'b0;
    wait_records(3);
    check_ax_rec(rec_q[0], axi_trace_pkg::chan_ar, ar_beat);
    check_ax_rec(rec_q[1], axi_trace_pkg::chan_aw, aw_beat);
    if (rec_q[2].chan !== axi_trace_pkg::chan_b || rec_q[2].id !== 8'h5a) begin
      report_error("third record of the round is not the B record");
    end
    drain();
  end
endtask

task automatic test_passthrough();
  axi_trace_pkg::ax_beat_t beat;
  int hs;
  beat = random_ax();
  @(negedge clk);
  ar_out_ready = 1'b0;
  aw_out_ready = 1'b0;
  b_out_ready = 1'b0;
  ar_in = beat;
  ar_in_valid = 1'b1;
  #1;
  if (ar_in_ready !== 1'b0 || !ar_out_valid || ar_out !== beat) begin
    report_error("AR passthrough wrong with subordinate not ready");
  end
  if (aw_in_ready !== 1'b0 || b_in_ready !== 1'b0) begin
    report_error("AW or B in_ready high with out_ready low");
  end
  @(negedge clk);
  ar_out_ready = 1'b1;
  aw_out_ready = 1'b1;
  b_out_ready = 1'b1;
  wait_ax(1'b0, beat, hs);
  send_ax(1'b1, random_ax(), hs);
  send_b('{id: 8'h11, resp: 2'b01});
  drain();
endtask

task automatic test_record_contents();
  axi_trace_pkg::ax_beat_t beat;
  int hs;
  beat = random_ax();
  send_ax(1'b0, beat, hs);
  #1;
  if (rec_tvalid) report_error("rec_tvalid high at the handshake edge");
  @(negedge clk);
  #1;
  if (rec_tvalid) report_error("rec_tvalid high one edge after the handshake");
  @(negedge clk);
  #1;
  if (!rec_tvalid) report_error("rec_tvalid low two edges after the handshake");
  wait_records(1);
  check_ax_rec(rec_q[0], axi_trace_pkg::chan_ar, beat);
  drain();
  send_b('{id: 8'h3c, resp: 2'b11});
  wait_records(1);
  if (rec_q[0].chan !== axi_trace_pkg::chan_b || rec_q[0].id !== 8'h3c ||
      rec_q[0].addr !== 32'h3 || rec_q[0].len !== 8'h0) begin
    report_error($sformatf("B record %h has wrong fields", rec_q[0]));
  end
  drain();
endtask

task automatic test_timestamps();
  int h1;
  int h2;
  logic [axi_trace_pkg::ts_w-1:0] diff;
  send_ax(1'b0, random_ax(), h1);
  repeat (4) @(negedge clk);
  send_ax(1'b0, random_ax(), h2);
  wait_records(2);
  diff = rec_q[1].ts - rec_q[0].ts;
  if (int'(diff) != h2 - h1) begin
    report_error($sformatf("ts difference %0d, expected %0d", diff, h2 - h1));
  end
  drain();
endtask

task automatic test_backpressure();
  axi_trace_pkg::ax_beat_t b1;
  axi_trace_pkg::ax_beat_t b2;
  axi_trace_pkg::ax_beat_t b3;
  axi_trace_pkg::trace_rec_t held;
  int hs;
  b1 = random_ax();
  b2 = random_ax();
  b3 = random_ax();
  rec_tready = 1'b0;
  send_ax(1'b0, b1, hs);
  while (!rec_tvalid) @(negedge clk);
  held = rec_tdata;
  // second beat is captured, then the tap holds it
  send_ax(1'b0, b2, hs);
  ar_in = b3;
  ar_in_valid = 1'b1;
  repeat (5) begin
    #1;
    if (ar_in_ready) report_error("AR not stalled behind a pending record");
    if (!rec_tvalid || rec_tdata !== held) report_error("stream beat changed while stalled");
    @(negedge clk);
  end
  rec_tready = 1'b1;
  wait_ax(1'b0, b3, hs);
  wait_records(3);
  check_ax_rec(rec_q[0], axi_trace_pkg::chan_ar, b1);
  check_ax_rec(rec_q[1], axi_trace_pkg::chan_ar, b2);
  check_ax_rec(rec_q[2], axi_trace_pkg::chan_ar, b3);
  drain();
endtask

task automatic test_enables();
  axi_trace_pkg::ax_beat_t beat;
  int hs;
  beat = random_ax();
  trace_enable[axi_trace_pkg::chan_aw - 1] = 1'b0;
  send_ax(1'b1, random_ax(), hs);
  send_ax(1'b0, beat, hs);
  repeat (8) @(negedge clk);
  if (rec_q.size() != 1) begin
    report_error($sformatf("%0d records with AW disabled, expected 1", rec_q.size()));
  end else begin
    check_ax_rec(rec_q[0], axi_trace_pkg::chan_ar, beat);
  end
  trace_enable = '1;
  drain();
endtask

// ==== verification/axi_trace_tb.sv ====
`timescale 1ns/1ps

module axi_trace_tb;

  localparam time clk_period = 100ns;
  localparam int watchdog_cycles = 2000;

  logic clk;
  logic resetn;
  logic [axi_trace_pkg::num_chan-1:0] trace_enable;

  axi_trace_pkg::ax_beat_t ar_in;
  axi_trace_pkg::ax_beat_t ar_out;
  logic ar_in_valid;
  logic ar_in_ready;
  logic ar_out_valid;
  logic ar_out_ready;

  axi_trace_pkg::ax_beat_t aw_in;
  axi_trace_pkg::ax_beat_t aw_out;
  logic aw_in_valid;
  logic aw_in_ready;
  logic aw_out_valid;
  logic aw_out_ready;

  axi_trace_pkg::b_beat_t b_in;
  axi_trace_pkg::b_beat_t b_out;
  logic b_in_valid;
  logic b_in_ready;
  logic b_out_valid;
  logic b_out_ready;

  axi_trace_pkg::trace_rec_t rec_tdata;
  logic rec_tvalid;
  logic rec_tready;

  int cyc = 0;
  int err_count = 0;
  int rec_total = 0;
  // records accepted by the stream sink, in arrival order
  axi_trace_pkg::trace_rec_t rec_q[$];

  axi_trace_top u_dut (
    .clk          (clk),
    .resetn       (resetn),
    .trace_enable (trace_enable),
    .ar_in        (ar_in),
    .ar_in_valid  (ar_in_valid),
    .ar_in_ready  (ar_in_ready),
    .ar_out       (ar_out),
    .ar_out_valid (ar_out_valid),
    .ar_out_ready (ar_out_ready),
    .aw_in        (aw_in),
    .aw_in_valid  (aw_in_valid),
    .aw_in_ready  (aw_in_ready),
    .aw_out       (aw_out),
    .aw_out_valid (aw_out_valid),
    .aw_out_ready (aw_out_ready),
    .b_in         (b_in),
    .b_in_valid   (b_in_valid),
    .b_in_ready   (b_in_ready),
    .b_out        (b_out),
    .b_out_valid  (b_out_valid),
    .b_out_ready  (b_out_ready),
    .rec_tdata    (rec_tdata),
    .rec_tvalid   (rec_tvalid),
    .rec_tready   (rec_tready)
  );

  initial clk = 1'b0;
  always #(clk_period / 2) clk = ~clk;

  // edge counter, value seen at a falling edge is the last rising edge
  always @(posedge clk) cyc <= cyc + 1;

  // stream sink, sampled mid-cycle where everything is settled
  always @(negedge clk) begin
    #10;
    if (resetn && rec_tvalid && rec_tready) begin
      rec_q.push_back(rec_tdata);
      rec_total++;
    end
  end

  initial begin
    #(watchdog_cycles * clk_period);
    $display("timeout: run did not finish within %0d clock periods", watchdog_cycles);
    $display("RESULT: FAIL");
    $finish;
  end

  `include "axi_trace_tests.svh"

  initial begin
    void'($urandom(32'ha7d));
    resetn = 1'b0;
    trace_enable = '1;
    ar_in = '0;
    ar_in_valid = 1'b0;
    ar_out_ready = 1'b1;
    aw_in = '0;
    aw_in_valid = 1'b0;
    aw_out_ready = 1'b1;
    b_in = '0;
    b_in_valid = 1'b0;
    b_out_ready = 1'b1;
    rec_tready = 1'b1;
    repeat (2) @(posedge clk);
    @(negedge clk);
    resetn = 1'b1;

    // pointer starts at B only right after reset
    test_round_robin();
    test_passthrough();
    test_record_contents();
    test_timestamps();
    test_backpressure();
    test_enables();

    $display("errors: %0d, records received: %0d", err_count, rec_total);
    if (err_count == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== all.f ====
+incdir+verification
src/axi_trace_pkg.sv
src/channel_tap.sv
src/trace_scheduler.sv
src/axi_trace_top.sv
verification/axi_trace_tb.sv

// ==== run.sh ====
#!/bin/sh
# builds and runs the trace tap testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
  --top-module axi_trace_tb \
  -f all.f

./obj_dir/Vaxi_trace_tb > sim.log
cat sim.log

if grep -q "RESULT: PASS" sim.log; then
  exit 0
else
  exit 1
fi
